// ==== design/decode_pkg.sv ====
////////////////////
// Shared decode types
// Operation, format and opcode enums
// Register index, data word and tag types
// Exception and output structs
////////////////////

`default_nettype none

package decode_pkg;

    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] xlen_t;
    typedef logic [2:0]  tag_t;

    // addi x0, x0, 0
    localparam xlen_t NOP_INSTRUCTION = 32'h00000013;

    ////////////////////
    // Operations
    ////////////////////

    typedef enum logic [5:0] {
        NOP,
        LUI,
        ADD, SUB, SLT, SLTU, XOR, OR, AND,
        SLL, SRL, SRA,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        JAL, JALR,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ECALL, EBREAK, SRET, MRET, WFI,
        CSRRW, CSRRS, CSRRC, CSRRWI, CSRRSI, CSRRCI,
        MUL, MULH, MULHSU, MULHU,
        DIV, DIVU, REM, REMU,
        AES32ESI, AES32ESMI,
        INVALID
    } op_e;

    typedef enum logic [2:0] {
        R_TYPE,
        I_TYPE,
        S_TYPE,
        B_TYPE,
        U_TYPE,
        J_TYPE
    } format_e;

    // Major opcodes, instruction bits 6 to 0
    typedef enum logic [6:0] {
        OPC_LOAD     = 7'b0000011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_OP_IMM   = 7'b0010011,
        OPC_AUIPC    = 7'b0010111,
        OPC_STORE    = 7'b0100011,
        OPC_OP       = 7'b0110011,
        OPC_LUI      = 7'b0110111,
        OPC_BRANCH   = 7'b1100011,
        OPC_JALR     = 7'b1100111,
        OPC_JAL      = 7'b1101111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_e;

    ////////////////////
    // Stage output
    ////////////////////

    typedef struct packed {
        logic illegal_inst;
        logic misaligned_fetch;
        logic access_fault;
    } dec_exc_t;

    typedef struct packed {
        op_e      operation;
        xlen_t    first_operand;
        xlen_t    second_operand;
        xlen_t    third_operand;
        xlen_t    pc;
        xlen_t    instruction;
        tag_t     tag;
        dec_exc_t exc;
    } dec_out_t;

endpackage

`default_nettype wire

// ==== design/op_decoder.sv ====
////////////////////
// Operation decoder
// Per-opcode sub-decoders and the final select
// Instruction format from the opcode
////////////////////

`timescale 1ns/1ps
`default_nettype none

module op_decoder
    import decode_pkg::*;
#(
    parameter bit AES_ENABLE = 1'b1
)
(
    input  xlen_t   instruction_i,
    output op_e     op_o,
    output format_e format_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    op_e dec_branch;
    op_e dec_load;
    op_e dec_store;
    op_e dec_op_imm;
    op_e dec_op;
    op_e dec_misc_mem;
    op_e dec_system;

    assign opcode = instruction_i[6:0];
    assign funct3 = instruction_i[14:12];
    assign funct7 = instruction_i[31:25];

    ////////////////////
    // Sub-decoders
    ////////////////////

    always_comb begin
        unique case (funct3)
            3'b000:  dec_branch = BEQ;
            3'b001:  dec_branch = BNE;
            3'b100:  dec_branch = BLT;
            3'b101:  dec_branch = BGE;
            3'b110:  dec_branch = BLTU;
            3'b111:  dec_branch = BGEU;
            default: dec_branch = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  dec_load = LB;
            3'b001:  dec_load = LH;
            3'b010:  dec_load = LW;
            3'b100:  dec_load = LBU;
            3'b101:  dec_load = LHU;
            default: dec_load = INVALID;
        endcase
    end

    always_comb begin
        unique case (funct3)
            3'b000:  dec_store = SB;
            3'b001:  dec_store = SH;
            3'b010:  dec_store = SW;
            default: dec_store = INVALID;
        endcase
    end

    // Shifts are the only immediate ops that look at funct7
    always_comb begin
        unique case ({funct7, funct3}) inside
            10'b???????000: dec_op_imm = ADD;
            10'b0000000001: dec_op_imm = SLL;
            10'b???????010: dec_op_imm = SLT;
            10'b???????011: dec_op_imm = SLTU;
            10'b???????100: dec_op_imm = XOR;
            10'b0000000101: dec_op_imm = SRL;
            10'b0100000101: dec_op_imm = SRA;
            10'b???????110: dec_op_imm = OR;
            10'b???????111: dec_op_imm = AND;
            default:        dec_op_imm = INVALID;
        endcase
    end

    // AES32 keeps the byte select in funct7 bits 6 and 5
    always_comb begin
        unique case ({funct7, funct3}) inside
            10'b0000000000: dec_op = ADD;
            10'b0100000000: dec_op = SUB;
            10'b0000000001: dec_op = SLL;
            10'b0000000010: dec_op = SLT;
            10'b0000000011: dec_op = SLTU;
            10'b0000000100: dec_op = XOR;
            10'b0000000101: dec_op = SRL;
            10'b0100000101: dec_op = SRA;
            10'b0000000110: dec_op = OR;
            10'b0000000111: dec_op = AND;
            10'b0000001000: dec_op = MUL;
            10'b0000001001: dec_op = MULH;
            10'b0000001010: dec_op = MULHSU;
            10'b0000001011: dec_op = MULHU;
            10'b0000001100: dec_op = DIV;
            10'b0000001101: dec_op = DIVU;
            10'b0000001110: dec_op = REM;
            10'b0000001111: dec_op = REMU;
            10'b??10001000: dec_op = AES_ENABLE ? AES32ESI : INVALID;
            10'b??10011000: dec_op = AES_ENABLE ? AES32ESMI : INVALID;
            default:        dec_op = INVALID;
        endcase
    end

    // Only FENCE, executed as a no-op
    always_comb begin
        unique case (funct3)
            3'b000:  dec_misc_mem = NOP;
            default: dec_misc_mem = INVALID;
        endcase
    end

    always_comb begin
        unique case (instruction_i[31:7]) inside
            25'b0000000000000000000000000: dec_system = ECALL;
            25'b0000000000010000000000000: dec_system = EBREAK;
            25'b0001000000100000000000000: dec_system = SRET;
            25'b0011000000100000000000000: dec_system = MRET;
            25'b0001000001010000000000000: dec_system = WFI;
            25'b?????????????????001?????: dec_system = CSRRW;
            25'b?????????????????010?????: dec_system = CSRRS;
            25'b?????????????????011?????: dec_system = CSRRC;
            25'b?????????????????101?????: dec_system = CSRRWI;
            25'b?????????????????110?????: dec_system = CSRRSI;
            25'b?????????????????111?????: dec_system = CSRRCI;
            default:                       dec_system = INVALID;
        endcase
    end

    ////////////////////
    // Opcode select
    ////////////////////

    always_comb begin
        unique case (opcode)
            OPC_LUI:      op_o = LUI;
            // AUIPC adds pc and immediate
            OPC_AUIPC:    op_o = ADD;
            OPC_JAL:      op_o = JAL;
            OPC_JALR:     op_o = JALR;
            OPC_BRANCH:   op_o = dec_branch;
            OPC_LOAD:     op_o = dec_load;
            OPC_STORE:    op_o = dec_store;
            OPC_OP_IMM:   op_o = dec_op_imm;
            OPC_OP:       op_o = dec_op;
            OPC_MISC_MEM: op_o = dec_misc_mem;
            OPC_SYSTEM:   op_o = dec_system;
            default:      op_o = INVALID;
        endcase
    end

    // Format from opcode bits 6 to 2
    always_comb begin
        unique case (opcode[6:2])
            5'b11001, 5'b00000, 5'b00100: format_o = I_TYPE;
            5'b01000:                     format_o = S_TYPE;
            5'b11000:                     format_o = B_TYPE;
            5'b01101, 5'b00101:           format_o = U_TYPE;
            5'b11011:                     format_o = J_TYPE;
            default:                      format_o = R_TYPE;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/imm_gen.sv ====
////////////////////
// Immediate generator
// I, S, B, U and J immediates
////////////////////

`timescale 1ns/1ps
`default_nettype none

module imm_gen
    import decode_pkg::*;
(
    input  xlen_t   instruction_i,
    input  format_e format_i,
    output xlen_t   imm_o
);

    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    assign imm_i = {{21{instruction_i[31]}}, instruction_i[30:20]};
    assign imm_s = {{21{instruction_i[31]}}, instruction_i[30:25], instruction_i[11:7]};

    // Branch and jump offsets are scattered and always even
    assign imm_b = {{20{instruction_i[31]}}, instruction_i[7], instruction_i[30:25],
                    instruction_i[11:8], 1'b0};
    assign imm_u = {instruction_i[31:12], 12'b0};
    assign imm_j = {{12{instruction_i[31]}}, instruction_i[19:12], instruction_i[20],
                    instruction_i[30:21], 1'b0};

    always_comb begin
        unique case (format_i)
            I_TYPE:  imm_o = imm_i;
            S_TYPE:  imm_o = imm_s;
            B_TYPE:  imm_o = imm_b;
            U_TYPE:  imm_o = imm_u;
            J_TYPE:  imm_o = imm_j;
            // R type has no immediate
            default: imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/hazard_unit.sv ====
////////////////////
// Hazard unit
// Replay of the held instruction
// Register and store lock, hazard detection
////////////////////

`timescale 1ns/1ps
`default_nettype none

module hazard_unit
    import decode_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     enable_i,
    input  xlen_t    instruction_i,
    input  format_e  format_i,
    output xlen_t    instruction_o,
    output logic     hazard_o,
    output reg_idx_t locked_rd_o
);

    xlen_t    last_instruction;
    logic     last_hazard;
    logic     last_stall;
    reg_idx_t locked_register;
    logic     locked_store;

    reg_idx_t rs1;
    reg_idx_t rs2;
    logic     use_rs1;
    logic     use_rs2;
    logic     is_mem;

    ////////////////////
    // Replay
    ////////////////////

    // Both flags set at reset so the first cycle decodes the NOP
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            last_instruction <= NOP_INSTRUCTION;
            last_hazard      <= 1'b1;
            last_stall       <= 1'b1;
        end else begin
            last_instruction <= instruction_o;
            last_hazard      <= hazard_o;
            last_stall       <= ~enable_i;
        end
    end

    assign instruction_o = (last_hazard || last_stall) ? last_instruction : instruction_i;

    ////////////////////
    // Lock
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            locked_register <= '0;
            locked_store    <= 1'b0;
        end else if (hazard_o) begin
            locked_register <= '0;
            locked_store    <= 1'b0;
        end else if (enable_i) begin
            locked_register <= instruction_o[11:7];
            locked_store    <= (instruction_o[6:0] == OPC_STORE);
        end
    end

    assign locked_rd_o = locked_register;

    ////////////////////
    // Detection
    ////////////////////

    assign rs1    = instruction_o[19:15];
    assign rs2    = instruction_o[24:20];
    assign is_mem = (instruction_o[6:0] == OPC_LOAD) || (instruction_o[6:0] == OPC_STORE);

    // Source usage by format, U and J read no registers
    assign use_rs1 = (format_i == R_TYPE) || (format_i == I_TYPE)
                  || (format_i == S_TYPE) || (format_i == B_TYPE);
    assign use_rs2 = (format_i == R_TYPE) || (format_i == S_TYPE) || (format_i == B_TYPE);

    assign hazard_o = enable_i && (
                          (use_rs1 && locked_register != '0 && locked_register == rs1)
                       || (use_rs2 && locked_register != '0 && locked_register == rs2)
                       || (locked_store && is_mem));

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
////////////////////
// Decode stage top level
// Operand select and exception bits
// Output register and rd delay
////////////////////

`timescale 1ns/1ps
`default_nettype none

module decode_stage
    import decode_pkg::*;
#(
    parameter bit AES_ENABLE = 1'b1
)
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     enable,

    input  xlen_t    instruction_i,
    input  xlen_t    pc_i,
    input  tag_t     tag_i,
    input  logic     access_fault_i,
    input  xlen_t    rs1_data_i,
    input  xlen_t    rs2_data_i,

    output reg_idx_t rs1_o,
    output reg_idx_t rs2_o,
    output reg_idx_t rd_o,
    output logic     hazard_o,
    output dec_out_t decode_o
);

    xlen_t    instruction;
    format_e  format;
    op_e      operation;
    xlen_t    immediate;
    reg_idx_t locked_rd;

    xlen_t    first_operand;
    xlen_t    second_operand;
    xlen_t    third_operand;
    dec_out_t decoded;
    dec_out_t bubble;

    ////////////////////
    // Submodules
    ////////////////////

    hazard_unit i_hazard_unit (
        .clk           (clk),
        .reset_n       (reset_n),
        .enable_i      (enable),
        .instruction_i (instruction_i),
        .format_i      (format),
        .instruction_o (instruction),
        .hazard_o      (hazard_o),
        .locked_rd_o   (locked_rd)
    );

    op_decoder #(
        .AES_ENABLE (AES_ENABLE)
    ) i_op_decoder (
        .instruction_i (instruction),
        .op_o          (operation),
        .format_o      (format)
    );

    imm_gen i_imm_gen (
        .instruction_i (instruction),
        .format_i      (format),
        .imm_o         (immediate)
    );

    // Register bank addresses
    assign rs1_o = instruction[19:15];
    assign rs2_o = instruction[24:20];

    ////////////////////
    // Operand select
    ////////////////////

    always_comb begin
        unique case (format)
            U_TYPE, J_TYPE: begin
                first_operand  = pc_i;
                second_operand = immediate;
                third_operand  = immediate;
            end
            R_TYPE, B_TYPE: begin
                first_operand  = rs1_data_i;
                second_operand = rs2_data_i;
                third_operand  = immediate;
            end
            // Store data rides in the third operand
            S_TYPE: begin
                first_operand  = rs1_data_i;
                second_operand = immediate;
                third_operand  = rs2_data_i;
            end
            default: begin
                first_operand  = rs1_data_i;
                second_operand = immediate;
                third_operand  = immediate;
            end
        endcase
    end

    always_comb begin
        decoded.operation            = operation;
        decoded.first_operand        = first_operand;
        decoded.second_operand       = second_operand;
        decoded.third_operand        = third_operand;
        decoded.pc                   = pc_i;
        decoded.instruction          = instruction;
        decoded.tag                  = tag_i;
        decoded.exc.illegal_inst     = (operation == INVALID);
        decoded.exc.misaligned_fetch = pc_i[0];
        decoded.exc.access_fault     = access_fault_i;
    end

    // NOP that only carries the tag
    always_comb begin
        bubble           = '0;
        bubble.operation = NOP;
        bubble.tag       = tag_i;
    end

    ////////////////////
    // Output registers
    ////////////////////

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            decode_o           <= '0;
            decode_o.operation <= NOP;
        end else if (hazard_o) begin
            decode_o <= bubble;
        end else if (enable) begin
            decode_o <= decoded;
        end
    end

    // rd follows decode_o by one cycle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_o <= '0;
        end else begin
            rd_o <= locked_rd;
        end
    end

endmodule

`default_nettype wire

// ==== tests/decode_checker.sv ====
////////////////////
// Decode stage checker
// Reference decode of op, format and immediate
// Replay and lock model, per-edge compare
////////////////////

`timescale 1ns/1ps
`default_nettype none

module decode_checker
    import decode_pkg::*;
#(
    parameter bit    AES_ENABLE  = 1'b1,
    parameter xlen_t REG_PATTERN = 32'h01010101
)
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     enable_i,
    input  xlen_t    instruction_i,
    input  xlen_t    pc_i,
    input  tag_t     tag_i,
    input  logic     access_fault_i,
    input  reg_idx_t rs1_i,
    input  reg_idx_t rs2_i,
    input  reg_idx_t rd_i,
    input  logic     hazard_i,
    input  dec_out_t decode_i,
    output int       errors_o,
    output int       checks_o,
    output int       hazards_o
);

    int       error_count  = 0;
    int       check_count  = 0;
    int       hazard_count = 0;

    // Model state
    xlen_t    replay;
    logic     last_hazard;
    logic     last_stall;
    reg_idx_t lock_rd;
    logic     lock_store;
    reg_idx_t exp_rd;
    dec_out_t exp_decode;

    xlen_t    selected;
    format_e  fmt;
    logic     uses_rs1;
    logic     uses_rs2;
    logic     is_mem;
    logic     exp_hazard;

    assign errors_o  = error_count;
    assign checks_o  = check_count;
    assign hazards_o = hazard_count;

    ////////////////////
    // Reference decode
    ////////////////////

    function automatic op_e alu_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return ADD;
            3'd1:    return SLL;
            3'd2:    return SLT;
            3'd3:    return SLTU;
            3'd4:    return XOR;
            3'd5:    return SRL;
            3'd6:    return OR;
            default: return AND;
        endcase
    endfunction

    function automatic op_e ref_op(input xlen_t ins);
        logic [2:0] f3;
        logic [6:0] f7;
        op_e        op;
        f3 = ins[14:12];
        f7 = ins[31:25];
        op = INVALID;
        case (ins[6:0])
            OPC_LUI:   op = LUI;
            OPC_AUIPC: op = ADD;
            OPC_JAL:   op = JAL;
            OPC_JALR:  op = JALR;
            OPC_BRANCH: begin
                case (f3)
                    3'd0: op = BEQ;
                    3'd1: op = BNE;
                    3'd4: op = BLT;
                    3'd5: op = BGE;
                    3'd6: op = BLTU;
                    3'd7: op = BGEU;
                    default: op = INVALID;
                endcase
            end
            OPC_LOAD: begin
                case (f3)
                    3'd0: op = LB;
                    3'd1: op = LH;
                    3'd2: op = LW;
                    3'd4: op = LBU;
                    3'd5: op = LHU;
                    default: op = INVALID;
                endcase
            end
            OPC_STORE: begin
                case (f3)
                    3'd0: op = SB;
                    3'd1: op = SH;
                    3'd2: op = SW;
                    default: op = INVALID;
                endcase
            end
            OPC_OP_IMM: begin
                if (f3 == 3'd1) begin
                    op = (f7 == 7'h00) ? SLL : INVALID;
                end else if (f3 == 3'd5) begin
                    op = (f7 == 7'h00) ? SRL : (f7 == 7'h20) ? SRA : INVALID;
                end else begin
                    op = alu_op(f3);
                end
            end
            OPC_OP: begin
                if (f7 == 7'h00) begin
                    op = alu_op(f3);
                end else if (f7 == 7'h01) begin
                    case (f3)
                        3'd0: op = MUL;
                        3'd1: op = MULH;
                        3'd2: op = MULHSU;
                        3'd3: op = MULHU;
                        3'd4: op = DIV;
                        3'd5: op = DIVU;
                        3'd6: op = REM;
                        default: op = REMU;
                    endcase
                end else if (f7 == 7'h20 && f3 == 3'd0) begin
                    op = SUB;
                end else if (f7 == 7'h20 && f3 == 3'd5) begin
                    op = SRA;
                end else if (AES_ENABLE && f3 == 3'd0 && f7[4:0] == 5'b10001) begin
                    op = AES32ESI;
                end else if (AES_ENABLE && f3 == 3'd0 && f7[4:0] == 5'b10011) begin
                    op = AES32ESMI;
                end
            end
            OPC_MISC_MEM: op = (f3 == 3'd0) ? NOP : INVALID;
            OPC_SYSTEM: begin
                case (f3)
                    3'd0: begin
                        // Privileged ops need rs1 and rd of zero
                        if (ins[19:7] == '0) begin
                            case (ins[31:20])
                                12'h000: op = ECALL;
                                12'h001: op = EBREAK;
                                12'h102: op = SRET;
                                12'h302: op = MRET;
                                12'h105: op = WFI;
                                default: op = INVALID;
                            endcase
                        end
                    end
                    3'd1: op = CSRRW;
                    3'd2: op = CSRRS;
                    3'd3: op = CSRRC;
                    3'd5: op = CSRRWI;
                    3'd6: op = CSRRSI;
                    3'd7: op = CSRRCI;
                    default: op = INVALID;
                endcase
            end
            default: op = INVALID;
        endcase
        return op;
    endfunction

    // Format from opcode bits 6 to 2 only
    function automatic format_e ref_format(input xlen_t ins);
        case (ins[6:2])
            5'b00000, 5'b00100, 5'b11001: return I_TYPE;
            5'b01000:                     return S_TYPE;
            5'b11000:                     return B_TYPE;
            5'b00101, 5'b01101:           return U_TYPE;
            5'b11011:                     return J_TYPE;
            default:                      return R_TYPE;
        endcase
    endfunction

    function automatic xlen_t ref_imm(input xlen_t ins, input format_e f);
        case (f)
            I_TYPE:  return {{20{ins[31]}}, ins[31:20]};
            S_TYPE:  return {{20{ins[31]}}, ins[31:25], ins[11:7]};
            B_TYPE:  return {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
            U_TYPE:  return {ins[31:12], 12'h000};
            J_TYPE:  return {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    function automatic dec_out_t ref_decode(input xlen_t ins, input xlen_t pc,
                                            input tag_t tag, input logic fault);
        dec_out_t d;
        format_e  f;
        xlen_t    imm;
        xlen_t    a;
        xlen_t    b;
        f   = ref_format(ins);
        imm = ref_imm(ins, f);
        a   = ins[19:15] * REG_PATTERN;
        b   = ins[24:20] * REG_PATTERN;
        d.operation      = ref_op(ins);
        d.first_operand  = (f == U_TYPE || f == J_TYPE) ? pc : a;
        d.second_operand = (f == R_TYPE || f == B_TYPE) ? b : imm;
        d.third_operand  = (f == S_TYPE) ? b : imm;
        d.pc             = pc;
        d.instruction    = ins;
        d.tag            = tag;
        d.exc            = {d.operation == INVALID, pc[0], fault};
        return d;
    endfunction

    ////////////////////
    // Compare
    ////////////////////

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("[FAIL] %s expected %h actual %h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic compare_decode(input dec_out_t expected, input dec_out_t actual);
        compare_value("decode_o.operation", expected.operation, actual.operation);
        compare_value("decode_o.first_operand", expected.first_operand,
                      actual.first_operand);
        compare_value("decode_o.second_operand", expected.second_operand,
                      actual.second_operand);
        compare_value("decode_o.third_operand", expected.third_operand,
                      actual.third_operand);
        compare_value("decode_o.pc", expected.pc, actual.pc);
        compare_value("decode_o.instruction", expected.instruction, actual.instruction);
        compare_value("decode_o.tag", expected.tag, actual.tag);
        compare_value("decode_o.exc", expected.exc, actual.exc);
    endtask

    // Registered outputs are compared against the previous edge's model
    always @(posedge clk) begin
        if (!reset_n) begin
            replay               = NOP_INSTRUCTION;
            last_hazard          = 1'b1;
            last_stall           = 1'b1;
            lock_rd              = '0;
            lock_store           = 1'b0;
            exp_rd               = '0;
            exp_decode           = '0;
            exp_decode.operation = NOP;
        end else begin
            selected   = (last_hazard || last_stall) ? replay : instruction_i;
            fmt        = ref_format(selected);
            uses_rs1   = fmt inside {R_TYPE, I_TYPE, S_TYPE, B_TYPE};
            uses_rs2   = fmt inside {R_TYPE, S_TYPE, B_TYPE};
            is_mem     = (selected[6:0] == OPC_LOAD) || (selected[6:0] == OPC_STORE);
            exp_hazard = enable_i && (
                             (uses_rs1 && lock_rd != '0 && lock_rd == selected[19:15])
                          || (uses_rs2 && lock_rd != '0 && lock_rd == selected[24:20])
                          || (lock_store && is_mem));

            compare_value("hazard_o", exp_hazard, hazard_i);
            compare_value("rs1_o", selected[19:15], rs1_i);
            compare_value("rs2_o", selected[24:20], rs2_i);
            compare_value("rd_o", exp_rd, rd_i);
            compare_decode(exp_decode, decode_i);
            check_count++;
            if (exp_hazard) begin
                hazard_count++;
            end

            // Next edge
            exp_rd = lock_rd;
            if (exp_hazard) begin
                exp_decode           = '0;
                exp_decode.operation = NOP;
                exp_decode.tag       = tag_i;
                lock_rd              = '0;
                lock_store           = 1'b0;
            end else if (enable_i) begin
                exp_decode = ref_decode(selected, pc_i, tag_i, access_fault_i);
                lock_rd    = selected[11:7];
                lock_store = (selected[6:0] == OPC_STORE);
            end
            replay      = selected;
            last_hazard = exp_hazard;
            last_stall  = !enable_i;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_decode.sv ====
////////////////////
// Decode stage testbench top
// Clock, reset, register bank model
// Random instruction stimulus and closing report
////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_decode
    import decode_pkg::*;
();

    localparam int    NUM_CYCLES    = 3000;
    // Last stimulus reaches decode_o two edges after it is driven
    localparam int    NUM_CHECKS    = NUM_CYCLES + 2;
    localparam int    DRAIN_TIMEOUT = 50;
    localparam xlen_t REG_PATTERN   = 32'h01010101;

    logic     clk = 1'b0;
    logic     reset_n;
    logic     enable;
    xlen_t    instruction;
    xlen_t    pc;
    tag_t     tag;
    logic     access_fault;
    xlen_t    rs1_data;
    xlen_t    rs2_data;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    logic     hazard;
    dec_out_t decode;

    integer   seed;
    int       mismatches;
    int       checks;
    int       hazards;
    int       other_errors;
    int       wait_cycles;
    xlen_t    next_instruction;
    xlen_t    ctrl_word;
    xlen_t    pc_word;

    always #50 clk = ~clk;

    // Register bank answers in the same cycle
    assign rs1_data = rs1 * REG_PATTERN;
    assign rs2_data = rs2 * REG_PATTERN;

    decode_stage #(
        .AES_ENABLE (1'b1)
    ) i_decode_stage (
        .clk            (clk),
        .reset_n        (reset_n),
        .enable         (enable),
        .instruction_i  (instruction),
        .pc_i           (pc),
        .tag_i          (tag),
        .access_fault_i (access_fault),
        .rs1_data_i     (rs1_data),
        .rs2_data_i     (rs2_data),
        .rs1_o          (rs1),
        .rs2_o          (rs2),
        .rd_o           (rd),
        .hazard_o       (hazard),
        .decode_o       (decode)
    );

    decode_checker #(
        .AES_ENABLE  (1'b1),
        .REG_PATTERN (REG_PATTERN)
    ) i_decode_checker (
        .clk            (clk),
        .reset_n        (reset_n),
        .enable_i       (enable),
        .instruction_i  (instruction),
        .pc_i           (pc),
        .tag_i          (tag),
        .access_fault_i (access_fault),
        .rs1_i          (rs1),
        .rs2_i          (rs2),
        .rd_i           (rd),
        .hazard_i       (hazard),
        .decode_i       (decode),
        .errors_o       (mismatches),
        .checks_o       (checks),
        .hazards_o      (hazards)
    );

    ////////////////////
    // Instruction mix
    ////////////////////

    // Registers x0 to x7 only, so that hazards come up often
    task automatic random_instruction(output xlen_t ins);
        int         kind;
        xlen_t      r;
        xlen_t      u;
        reg_idx_t   rd_f;
        reg_idx_t   rs1_f;
        reg_idx_t   rs2_f;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] sys_imm;
        kind  = {$random(seed)} % 18;
        r     = $random(seed);
        u     = $random(seed);
        rd_f  = {2'b00, r[2:0]};
        rs1_f = {2'b00, r[5:3]};
        rs2_f = {2'b00, r[8:6]};
        f3    = r[11:9];
        case (u[1:0])
            2'd0:    f7 = 7'h00;
            2'd1:    f7 = 7'h20;
            2'd2:    f7 = 7'h01;
            default: f7 = u[31:25];
        endcase
        case (u[4:2])
            3'd0:    sys_imm = 12'h000;
            3'd1:    sys_imm = 12'h001;
            3'd2:    sys_imm = 12'h102;
            3'd3:    sys_imm = 12'h302;
            3'd4:    sys_imm = 12'h105;
            default: sys_imm = u[31:20];
        endcase
        case (kind)
            0:       ins = {u[19:0], rd_f, OPC_LUI};
            1:       ins = {u[19:0], rd_f, OPC_AUIPC};
            2:       ins = {u[19:0], rd_f, OPC_JAL};
            3:       ins = {u[11:0], rs1_f, 3'b000, rd_f, OPC_JALR};
            4, 5:    ins = {u[6:0], rs2_f, rs1_f, f3, u[11:7], OPC_BRANCH};
            6:       ins = {u[11:0], rs1_f, f3, rd_f, OPC_LOAD};
            7, 8:    ins = {u[6:0], rs2_f, rs1_f, 1'b0, f3[1:0], u[11:7], OPC_STORE};
            9, 10: begin
                ins = {u[11:0], rs1_f, f3, rd_f, OPC_OP_IMM};
                // Shifts mostly get a legal funct7
                if (f3[1:0] == 2'b01 && !u[13]) begin
                    ins[31:25] = {1'b0, u[12], 5'b00000};
                end
            end
            11, 12:  ins = {f7, rs2_f, rs1_f, f3, rd_f, OPC_OP};
            13:      ins = {u[1:0], u[2] ? 5'b10011 : 5'b10001, rs2_f, rs1_f, 3'b000,
                            rd_f, OPC_OP};
            14:      ins = {u[11:0], 5'b00000, 2'b00, u[12], 5'b00000, OPC_MISC_MEM};
            15:      ins = {sys_imm, 13'h0000, OPC_SYSTEM};
            16:      ins = {u[11:0], rs1_f, f3, rd_f, OPC_SYSTEM};
            default: ins = u;
        endcase
    endtask

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        seed         = 32'hd2cd0a55;
        other_errors = 0;
        reset_n      = 1'b0;
        enable       = 1'b0;
        instruction  = NOP_INSTRUCTION;
        pc           = '0;
        tag          = '0;
        access_fault = 1'b0;

        repeat (10) @(posedge clk);
        reset_n <= 1'b1;

        for (int i = 0; i < NUM_CYCLES; i++) begin
            @(posedge clk);
            random_instruction(next_instruction);
            ctrl_word = $random(seed);
            pc_word   = $random(seed);
            instruction  <= next_instruction;
            // Odd pc, access fault and stall are each occasional
            pc           <= {pc_word[31:1], (ctrl_word[3:0] == 4'h0)};
            tag          <= ctrl_word[6:4];
            access_fault <= (ctrl_word[10:7] == 4'h0);
            enable       <= (ctrl_word[13:11] != 3'h0);
        end

        wait_cycles = 0;
        while (checks < NUM_CHECKS && wait_cycles < DRAIN_TIMEOUT) begin
            @(posedge clk);
            wait_cycles++;
        end
        if (checks < NUM_CHECKS) begin
            $display("Timeout while waiting for the checker to finish its comparisons");
            other_errors++;
        end
        if (hazards == 0) begin
            $display("No hazard was raised during the whole run");
            other_errors++;
        end

        $display("Errors: %0d mismatches, %0d other, %0d cycles checked",
                 mismatches, other_errors, checks);
        if (mismatches == 0 && other_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
design/decode_pkg.sv
design/op_decoder.sv
design/imm_gen.sv
design/hazard_unit.sv
design/decode_stage.sv
tests/decode_checker.sv
tests/tb_decode.sv
